/* files.f */
source/ex_pkg.sv
source/ex_dispatch.sv
source/ex_alu.sv
source/ex_stages.sv
source/ex_writeback.sv
source/ex_unit.sv
sim/ex_unit_checker.sv
sim/ex_unit_tb.sv

/* Makefile */
# Verilator flow for the execute and writeback subsystem

VERILATOR ?= verilator
TOP       ?= ex_unit_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# The log decides the result, the exit status of the binary is not used
sim: build
	$(EXE) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation ended without a result line, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/ex_unit_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_unit_tb;

  import ex_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 16;
  localparam int IDLE_CYCLES     = 4;
  localparam int NUM_ROWS        = 24;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * 8 + 40;
  localparam int DRAIN_CYCLES    = 20;
  localparam int SETTLE_CYCLES   = 8;

  logic    clk_i;
  logic    rst_i;
  logic    issue_valid_i;
  issue_t  issue_i;
  logic    issue_ready_o;
  result_t wb_o;

  // Stimulus table with hand-computed expected values
  string                     row_name    [NUM_ROWS];
  alu_op_e                   row_op      [NUM_ROWS];
  logic [REG_ADDR_WIDTH-1:0] row_rd      [NUM_ROWS];
  logic [DATA_WIDTH-1:0]     row_a       [NUM_ROWS];
  logic [DATA_WIDTH-1:0]     row_b       [NUM_ROWS];
  logic [DATA_WIDTH-1:0]     row_exp     [NUM_ROWS];
  bit                        row_written [NUM_ROWS];
  int                        row_count = 0;

  int check_count    = 0;
  int error_count    = 0;
  int assert_fails   = 0;
  int stall_count    = 0;
  int write_count    = 0;
  bit first_accepted = 1'b0;

  ex_unit u_ex_unit (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_i       (issue_i),
    .issue_ready_o (issue_ready_o),
    .wb_o          (wb_o)
  );

  bind ex_dispatch ex_unit_checker u_dispatch_chk (
    .clk_i (clk_i), .rst_i (rst_i),
    .issue_valid_i (issue_valid_i), .issue_ready_i (issue_ready_o), .issue_i (issue_i),
    .alu_valid_i (alu_valid_o), .mul_valid_i (mul_valid_o),
    .alu_res_i ('0), .mul_res_i ('0), .wb_i ('0)
  );

  bind ex_writeback ex_unit_checker u_writeback_chk (
    .clk_i (clk_i), .rst_i (rst_i),
    .issue_valid_i (1'b0), .issue_ready_i (1'b1), .issue_i ('0),
    .alu_valid_i (1'b0), .mul_valid_i (1'b0),
    .alu_res_i (alu_res_i), .mul_res_i (mul_res_i), .wb_i (wb_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH %s: expected %08h, actual %08h", name, expected, actual);
    end
  endtask

  task automatic add_row(input string name, input alu_op_e op,
                         input logic [REG_ADDR_WIDTH-1:0] rd,
                         input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
                         input logic [DATA_WIDTH-1:0] expected);
    row_name[row_count]    = name;
    row_op[row_count]      = op;
    row_rd[row_count]      = rd;
    row_a[row_count]       = a;
    row_b[row_count]       = b;
    row_exp[row_count]     = expected;
    row_written[row_count] = 1'b0;
    row_count++;
  endtask

  task automatic load_table();
    add_row("add_basic",        OP_ADD, 5'd1,  32'h0000_0005, 32'h0000_0007, 32'h0000_000c);
    add_row("add_wrap",         OP_ADD, 5'd2,  32'hffff_ffff, 32'h0000_0002, 32'h0000_0001);
    add_row("sub_basic",        OP_SUB, 5'd3,  32'h0000_0010, 32'h0000_0003, 32'h0000_000d);
    add_row("sub_negative",     OP_SUB, 5'd4,  32'h0000_0003, 32'h0000_0005, 32'hffff_fffe);
    add_row("and_mask",         OP_AND, 5'd5,  32'hf0f0_1234, 32'h0ff0_ff00, 32'h00f0_1200);
    add_row("or_merge",         OP_OR,  5'd6,  32'hf000_000f, 32'h0f00_00f0, 32'hff00_00ff);
    add_row("xor_toggle",       OP_XOR, 5'd7,  32'haaaa_5555, 32'hffff_0000, 32'h5555_5555);
    add_row("sll_by_4",         OP_SLL, 5'd8,  32'h0000_0001, 32'h0000_0004, 32'h0000_0010);
    add_row("sll_low_bits",     OP_SLL, 5'd9,  32'h0000_0003, 32'h0000_0021, 32'h0000_0006);
    add_row("srl_logical",      OP_SRL, 5'd10, 32'h8000_0000, 32'h0000_001f, 32'h0000_0001);
    add_row("srl_low_bits",     OP_SRL, 5'd11, 32'hf000_0000, 32'hffff_ffe4, 32'h0f00_0000);
    add_row("slt_signed_true",  OP_SLT, 5'd12, 32'hffff_ffff, 32'h0000_0001, 32'h0000_0001);
    add_row("slt_signed_false", OP_SLT, 5'd13, 32'h0000_0001, 32'h8000_0000, 32'h0000_0000);
    add_row("rd_zero_add",      OP_ADD, 5'd0,  32'h1234_5678, 32'h1111_1111, 32'h2345_6789);
    // Five back-to-back multiplies hold off the ALU rows behind them
    add_row("mul_small",        OP_MUL, 5'd14, 32'h0000_0006, 32'h0000_0007, 32'h0000_002a);
    add_row("mul_negative",     OP_MUL, 5'd15, 32'hffff_fffd, 32'h0000_0005, 32'hffff_fff1);
    add_row("mul_both_neg",     OP_MUL, 5'd16, 32'hffff_fffe, 32'hffff_fff9, 32'h0000_000e);
    add_row("mul_overflow",     OP_MUL, 5'd17, 32'h0001_0001, 32'h0001_0001, 32'h0002_0001);
    add_row("mul_large",        OP_MUL, 5'd18, 32'h1234_5678, 32'h0000_0010, 32'h2345_6780);
    add_row("add_after_mul",    OP_ADD, 5'd19, 32'h0000_0100, 32'h0000_0023, 32'h0000_0123);
    add_row("xor_after_mul",    OP_XOR, 5'd20, 32'h0000_ffff, 32'h0000_0f0f, 32'h0000_f0f0);
    add_row("slt_equal",        OP_SLT, 5'd21, 32'h7fff_ffff, 32'h7fff_ffff, 32'h0000_0000);
    add_row("mul_square",       OP_MUL, 5'd22, 32'h0000_ffff, 32'h0000_ffff, 32'hfffe_0001);
    add_row("and_last",         OP_AND, 5'd23, 32'hffff_ffff, 32'h1357_9bdf, 32'h1357_9bdf);
  endtask

  function automatic int find_row(input logic [REG_ADDR_WIDTH-1:0] rd);
    int found;
    found = -1;
    for (int i = 0; i < row_count; i++) begin
      if (row_rd[i] == rd) found = i;
    end
    return found;
  endfunction

  // Ready is settled a quarter period after the falling edge and holds until the rising one
  task automatic issue_row(input int idx);
    @(negedge clk_i);
    issue_valid_i = 1'b1;
    issue_i.op    = row_op[idx];
    issue_i.rd    = row_rd[idx];
    issue_i.a     = row_a[idx];
    issue_i.b     = row_b[idx];
    #(CLK_PERIOD / 4);
    while (!issue_ready_o) begin
      if (row_op[idx] == OP_MUL) begin
        error_count++;
        $display("Issue ready went low for multiply row %s", row_name[idx]);
      end
      stall_count++;
      @(negedge clk_i);
      #(CLK_PERIOD / 4);
    end
    first_accepted = 1'b1;
  endtask

  ////////////////////////////////////////
  // Writeback monitor
  ////////////////////////////////////////

  always @(negedge clk_i) begin : wb_monitor
    int idx;
    if (wb_o.valid === 1'b1) begin
      if (!first_accepted) begin
        error_count++;
        $display("Writeback seen before any instruction was accepted");
      end
      idx = find_row(wb_o.rd);
      if (wb_o.rd == '0) begin
        error_count++;
        $display("Writeback to register zero with data %08h", wb_o.data);
      end else if (idx < 0) begin
        error_count++;
        $display("Writeback for rd %0d, which no row uses", wb_o.rd);
      end else if (row_written[idx]) begin
        error_count++;
        $display("Second writeback for row %s (rd %0d)", row_name[idx], wb_o.rd);
      end else begin
        row_written[idx] = 1'b1;
        write_count++;
        check_value(row_name[idx], row_exp[idx], wb_o.data);
      end
    end
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin : stimulus
    int expected_writes;
    int wait_cycles;
    rst_i         = 1'b0;
    issue_valid_i = 1'b0;
    issue_i       = '0;
    load_table();
    expected_writes = 0;
    for (int i = 0; i < row_count; i++) begin
      if (row_rd[i] != '0) expected_writes++;
    end

    repeat (RESET_CYCLES) @(negedge clk_i);
    rst_i = 1'b1;
    repeat (IDLE_CYCLES) begin
      @(negedge clk_i);
      check_value("idle_wb_valid", 32'h0, {31'h0, wb_o.valid});
    end

    for (int i = 0; i < row_count; i++) begin
      issue_row(i);
    end
    @(negedge clk_i);
    issue_valid_i = 1'b0;
    issue_i       = '0;

    wait_cycles = 0;
    while (write_count < expected_writes && wait_cycles < DRAIN_CYCLES) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    // Extra cycles catch late or repeated writebacks
    repeat (SETTLE_CYCLES) @(negedge clk_i);

    for (int i = 0; i < row_count; i++) begin
      if (row_rd[i] != '0 && !row_written[i]) begin
        error_count++;
        $display("Row %s (rd %0d) never wrote back", row_name[i], row_rd[i]);
      end
    end
    if (stall_count == 0) begin
      error_count++;
      $display("Issue ready never went low during the multiply run");
    end

    assert_fails = u_ex_unit.u_dispatch.u_dispatch_chk.fail_count
                 + u_ex_unit.u_writeback.u_writeback_chk.fail_count;
    $display("Summary: %0d checks, %0d errors, %0d assertion failures, %0d stall cycles",
             check_count, error_count, assert_fails, stall_count);
    if (error_count == 0 && assert_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule : ex_unit_tb

`default_nettype wire

/* sim/ex_unit_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_unit_checker (
  input  logic            clk_i,
  input  logic            rst_i,
  // Issue side, seen at the dispatcher
  input  logic            issue_valid_i,
  input  logic            issue_ready_i,
  input  ex_pkg::issue_t  issue_i,
  input  logic            alu_valid_i,
  input  logic            mul_valid_i,
  // Result side, seen at the writeback merger
  input  ex_pkg::result_t alu_res_i,
  input  ex_pkg::result_t mul_res_i,
  input  ex_pkg::result_t wb_i
);

  import ex_pkg::*;

  int fail_count = 0;

  ////////////////////////////////////////
  // Dispatch rules
  ////////////////////////////////////////

  a_one_unit: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(alu_valid_i && mul_valid_i))
    else begin
      fail_count++;
      $error("ALU and multiplier strobes high in the same cycle");
    end

  // Source keeps the instruction steady through a stall
  a_stall_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
    (issue_valid_i && !issue_ready_i) |=> (issue_valid_i && $stable(issue_i)))
    else begin
      fail_count++;
      $error("Stalled issue dropped valid or changed its payload");
    end

  ////////////////////////////////////////
  // Writeback rules
  ////////////////////////////////////////

  a_no_collision: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(alu_res_i.valid && mul_res_i.valid))
    else begin
      fail_count++;
      $error("ALU and multiplier results collide at writeback");
    end

  a_no_rd_zero: assert property (@(posedge clk_i) disable iff (!rst_i)
    wb_i.valid |-> (wb_i.rd != '0))
    else begin
      fail_count++;
      $error("Writeback port is valid with rd zero");
    end

endmodule : ex_unit_checker

`default_nettype wire

/* source/ex_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_unit (
  input  logic            clk_i,
  input  logic            rst_i,
  // Issue port
  input  logic            issue_valid_i,
  input  ex_pkg::issue_t  issue_i,
  output logic            issue_ready_o,
  // Register write port, no back-pressure
  output ex_pkg::result_t wb_o
);

  import ex_pkg::*;

  logic    alu_valid;
  logic    mul_valid;
  logic    wb_next;
  result_t alu_res;
  result_t mul_res;

  ////////////////////////////////////////
  // Dispatch
  ////////////////////////////////////////

  ex_dispatch u_dispatch (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .issue_valid_i (issue_valid_i),
    .issue_i       (issue_i),
    .issue_ready_o (issue_ready_o),
    .wb_next_i     (wb_next),
    .alu_valid_o   (alu_valid),
    .mul_valid_o   (mul_valid)
  );

  ////////////////////////////////////////
  // Execution units
  ////////////////////////////////////////

  // Both units see the same payload, only the strobe differs
  ex_alu u_alu (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (alu_valid),
    .issue_i (issue_i),
    .res_o   (alu_res)
  );

  ex_stages u_mul (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .valid_i            (mul_valid),
    .issue_i            (issue_i),
    .wb_is_next_cycle_o (wb_next),
    .res_o              (mul_res)
  );

  ////////////////////////////////////////
  // Writeback
  ////////////////////////////////////////

  ex_writeback u_writeback (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .alu_res_i (alu_res),
    .mul_res_i (mul_res),
    .wb_o      (wb_o)
  );

endmodule : ex_unit

`default_nettype wire

/* source/ex_writeback.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_writeback (
  input  logic            clk_i,
  input  logic            rst_i,
  input  ex_pkg::result_t alu_res_i,
  input  ex_pkg::result_t mul_res_i,
  output ex_pkg::result_t wb_o
);

  import ex_pkg::*;

  result_t                   sel_res;
  logic                      sel_write;

  logic                      wb_valid_q;
  logic [REG_ADDR_WIDTH-1:0] wb_rd_q;
  logic [DATA_WIDTH-1:0]     wb_data_q;

  ////////////////////////////////////////
  // Merge
  ////////////////////////////////////////

  // Dispatch keeps the two inputs apart, so a plain priority is enough
  assign sel_res = mul_res_i.valid ? mul_res_i : alu_res_i;

  // Register zero is hardwired, a write to it is discarded here
  assign sel_write = sel_res.valid && (sel_res.rd != '0);

  ////////////////////////////////////////
  // Output register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= sel_write;
    end
  end

  always_ff @(posedge clk_i) begin
    wb_rd_q   <= sel_res.rd;
    wb_data_q <= sel_res.data;
  end

  assign wb_o.valid = wb_valid_q;
  assign wb_o.rd    = wb_rd_q;
  assign wb_o.data  = wb_data_q;

endmodule : ex_writeback

`default_nettype wire

/* source/ex_stages.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_stages (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            valid_i,
  input  ex_pkg::issue_t  issue_i,
  // High while stage four holds a multiply
  output logic            wb_is_next_cycle_o,
  output ex_pkg::result_t res_o
);

  import ex_pkg::*;

  localparam int LAST = MUL_LATENCY - 1;

  // Index 0 is the first stage, LAST is the output stage
  logic [MUL_LATENCY-1:0]    valid_q;
  logic [REG_ADDR_WIDTH-1:0] rd_q   [MUL_LATENCY];
  logic [DATA_WIDTH-1:0]     prod_q [MUL_LATENCY];

  ////////////////////////////////////////
  // Valid chain
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[MUL_LATENCY-2:0], valid_i};
    end
  end

  ////////////////////////////////////////
  // Payload chain
  ////////////////////////////////////////

  // The product is formed in the first stage, the rest only carry it
  always_ff @(posedge clk_i) begin
    rd_q[0]   <= issue_i.rd;
    prod_q[0] <= issue_i.a * issue_i.b;
    for (int i = 1; i < MUL_LATENCY; i++) begin
      rd_q[i]   <= rd_q[i-1];
      prod_q[i] <= prod_q[i-1];
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // One cycle of warning before the result appears
  assign wb_is_next_cycle_o = valid_q[LAST-1];

  assign res_o.valid = valid_q[LAST];
  assign res_o.rd    = rd_q[LAST];
  assign res_o.data  = prod_q[LAST];

endmodule : ex_stages

`default_nettype wire

/* source/ex_alu.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_alu (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            valid_i,
  input  ex_pkg::issue_t  issue_i,
  output ex_pkg::result_t res_o
);

  import ex_pkg::*;

  logic [SHAMT_WIDTH-1:0]    shamt;
  logic                      slt_bit;
  logic [DATA_WIDTH-1:0]     alu_data;

  logic                      res_valid_q;
  logic [REG_ADDR_WIDTH-1:0] res_rd_q;
  logic [DATA_WIDTH-1:0]     res_data_q;

  ////////////////////////////////////////
  // Combinational datapath
  ////////////////////////////////////////

  assign shamt   = issue_i.b[SHAMT_WIDTH-1:0];
  assign slt_bit = ($signed(issue_i.a) < $signed(issue_i.b));

  always_comb begin
    unique case (issue_i.op)
      OP_ADD:  alu_data = issue_i.a + issue_i.b;
      OP_SUB:  alu_data = issue_i.a - issue_i.b;
      OP_AND:  alu_data = issue_i.a & issue_i.b;
      OP_OR:   alu_data = issue_i.a | issue_i.b;
      OP_XOR:  alu_data = issue_i.a ^ issue_i.b;
      OP_SLL:  alu_data = issue_i.a << shamt;
      OP_SRL:  alu_data = issue_i.a >> shamt;
      OP_SLT:  alu_data = {{(DATA_WIDTH-1){1'b0}}, slt_bit};
      // Multiplies never reach this unit
      default: alu_data = '0;
    endcase
  end

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    res_rd_q   <= issue_i.rd;
    res_data_q <= alu_data;
  end

  assign res_o.valid = res_valid_q;
  assign res_o.rd    = res_rd_q;
  assign res_o.data  = res_data_q;

endmodule : ex_alu

`default_nettype wire

/* source/ex_dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_dispatch (
  input  logic           clk_i,
  input  logic           rst_i,
  // Issue port
  input  logic           issue_valid_i,
  input  ex_pkg::issue_t issue_i,
  output logic           issue_ready_o,
  // Warning from the multiplier
  input  logic           wb_next_i,
  // Unit strobes
  output logic           alu_valid_o,
  output logic           mul_valid_o
);

  import ex_pkg::*;

  logic is_mul;
  logic alu_conflict;
  logic accept;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Everything that is not a multiply goes to the ALU
  assign is_mul = (issue_i.op == OP_MUL);

  // An ALU result issued now would land on the same writeback
  // cycle as the multiply that sits in stage four
  assign alu_conflict = !is_mul && wb_next_i;

  ////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////

  // Ready depends only on the op and the warning, never on valid
  assign issue_ready_o = !alu_conflict;

  assign accept = issue_valid_i && issue_ready_o;

  // Exactly one unit sees each accepted instruction
  assign alu_valid_o = accept && !is_mul;
  assign mul_valid_o = accept && is_mul;

  // clk_i and rst_i give the bound checker its sampling clock and
  // disable condition, the routing itself holds no state

endmodule : ex_dispatch

`default_nettype wire

/* source/ex_pkg.sv */
`default_nettype none

package ex_pkg;

  ////////////////////////////////////////
  // Widths and latencies
  ////////////////////////////////////////

  localparam int DATA_WIDTH     = 32;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int SHAMT_WIDTH    = $clog2(DATA_WIDTH);
  localparam int MUL_LATENCY    = 5;

  ////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////

  // Shifts take the low bits of b, SLT compares signed
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SLL = 4'd5,
    OP_SRL = 4'd6,
    OP_SLT = 4'd7,
    OP_MUL = 4'd8
  } alu_op_e;

  ////////////////////////////////////////
  // Payloads
  ////////////////////////////////////////

  // Instruction at the issue port
  typedef struct packed {
    alu_op_e                   op;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [DATA_WIDTH-1:0]     a;
    logic [DATA_WIDTH-1:0]     b;
  } issue_t;

  // Unit result and writeback port
  typedef struct packed {
    logic                      valid;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [DATA_WIDTH-1:0]     data;
  } result_t;

endpackage : ex_pkg

`default_nettype wire
